// File: build.f
sdram_wb_pkg.sv
ahb_write_decode.sv
wb_storage.sv
wb_flush_ctrl.sv
sdram_wb_top.sv
tb_sdram_model.sv
tb_sdram_wb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdram_wb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_sdram_wb.sv
/* Testbench top: stimulus table, reference copy of the
   write buffer, request checks and timeouts */

`timescale 1ns/1ps

module tb_sdram_wb;

  typedef struct packed {
    sdram_wb_pkg::haddr_t   addr;
    logic [2:0]             size;
    sdram_wb_pkg::hdata_t   data;
    sdram_wb_pkg::timeout_t tmo;
    logic                   slow;
    logic [7:0]             idle;
  } stim_t;

  localparam int NROWS = 20;

  logic                   HCLK = 1'b0;
  logic                   HRESETn;
  logic                   hsel_i;
  logic [1:0]             htrans_i;
  logic                   hwrite_i;
  logic [2:0]             hsize_i;
  sdram_wb_pkg::haddr_t   haddr_i;
  sdram_wb_pkg::hdata_t   hwdata_i;
  logic                   hready_i;
  logic                   hreadyout_o;
  logic                   wrreq_o;
  sdram_wb_pkg::wb_req_t  wr_req_o;
  logic                   wrrdy_i;
  sdram_wb_pkg::timeout_t timeout_i;
  logic                   slow_mode;
  logic                   rec_valid;
  sdram_wb_pkg::wb_req_t  rec_req;
  logic                   hold_err;

  // Rows: address, size, bus word, timer exponent, slow scheduler, idle cycles
  stim_t stim [NROWS] = '{
    // One line filled by words, flushed by the timer
    '{32'h0000_1000, sdram_wb_pkg::HSIZE_WORD,  32'h1111_1111, 4'd2, 1'b0, 8'd1},
    '{32'h0000_1004, sdram_wb_pkg::HSIZE_WORD,  32'h2222_2222, 4'd2, 1'b0, 8'd1},
    '{32'h0000_1008, sdram_wb_pkg::HSIZE_WORD,  32'h3333_3333, 4'd2, 1'b0, 8'd1},
    '{32'h0000_100C, sdram_wb_pkg::HSIZE_WORD,  32'h4444_4444, 4'd2, 1'b0, 8'd12},
    // Byte lanes, overlap on 0x200B
    '{32'h0000_2001, sdram_wb_pkg::HSIZE_BYTE,  32'h0000_AA00, 4'd2, 1'b0, 8'd1},
    '{32'h0000_2006, sdram_wb_pkg::HSIZE_HWORD, 32'hBEEF_0000, 4'd2, 1'b0, 8'd1},
    '{32'h0000_2008, sdram_wb_pkg::HSIZE_WORD,  32'h1234_5678, 4'd2, 1'b0, 8'd1},
    '{32'h0000_200B, sdram_wb_pkg::HSIZE_BYTE,  32'h9900_0000, 4'd2, 1'b0, 8'd1},
    '{32'h0000_2002, sdram_wb_pkg::HSIZE_HWORD, 32'h7777_0000, 4'd2, 1'b0, 8'd20},
    // Misses with a quick scheduler
    '{32'h0000_3000, sdram_wb_pkg::HSIZE_WORD,  32'hCAFE_0001, 4'd3, 1'b0, 8'd2},
    '{32'h0000_4004, sdram_wb_pkg::HSIZE_WORD,  32'hCAFE_0002, 4'd3, 1'b0, 8'd2},
    '{32'h0000_4008, sdram_wb_pkg::HSIZE_BYTE,  32'h0000_00EE, 4'd3, 1'b0, 8'd2},
    '{32'h0000_5000, sdram_wb_pkg::HSIZE_WORD,  32'hCAFE_0003, 4'd3, 1'b0, 8'd2},
    // Back-to-back misses against a slow scheduler
    '{32'h0000_6000, sdram_wb_pkg::HSIZE_WORD,  32'h6000_0001, 4'd3, 1'b1, 8'd1},
    '{32'h0000_7000, sdram_wb_pkg::HSIZE_WORD,  32'h7000_0001, 4'd3, 1'b1, 8'd1},
    '{32'h0000_8000, sdram_wb_pkg::HSIZE_WORD,  32'h8000_0001, 4'd3, 1'b1, 8'd1},
    '{32'h0000_8004, sdram_wb_pkg::HSIZE_HWORD, 32'h0000_8181, 4'd3, 1'b1, 8'd1},
    '{32'h0000_9000, sdram_wb_pkg::HSIZE_WORD,  32'h9000_0001, 4'd3, 1'b1, 8'd1},
    '{32'h0000_9008, sdram_wb_pkg::HSIZE_WORD,  32'h9000_0002, 4'd3, 1'b1, 8'd30},
    // Timer off, line must stay put
    '{32'h0000_A000, sdram_wb_pkg::HSIZE_WORD,  32'hA000_0001, 4'd0, 1'b0, 8'd200}
  };

  // Reference copy of the active line
  sdram_wb_pkg::tag_t       act_tag;
  sdram_wb_pkg::line_be_t   act_be;
  sdram_wb_pkg::line_data_t act_data;
  logic                     act_dirty;

  sdram_wb_pkg::wb_req_t    exp_q [$];
  sdram_wb_pkg::wb_req_t    exp_req;
  sdram_wb_pkg::line_data_t mask;
  int                       push_count;
  int                       got_count;
  int                       stall_count;

  // Single slave on the bus
  assign hready_i = hreadyout_o;

  always #50 HCLK = ~HCLK;

  sdram_wb_top u_sdram_wb_top (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .hsel_i      (hsel_i),
    .htrans_i    (htrans_i),
    .hwrite_i    (hwrite_i),
    .hsize_i     (hsize_i),
    .haddr_i     (haddr_i),
    .hwdata_i    (hwdata_i),
    .hready_i    (hready_i),
    .hreadyout_o (hreadyout_o),
    .wrreq_o     (wrreq_o),
    .wr_req_o    (wr_req_o),
    .wrrdy_i     (wrrdy_i),
    .timeout_i   (timeout_i)
  );

  tb_sdram_model u_sdram_model (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .wrreq_i     (wrreq_o),
    .wr_req_i    (wr_req_o),
    .slow_i      (slow_mode),
    .wrrdy_o     (wrrdy_i),
    .rec_valid_o (rec_valid),
    .rec_req_o   (rec_req),
    .hold_err_o  (hold_err)
  );

  ////////////////////
  // Checks

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("Test failed");
    $fatal(1);
  endtask

  // Byte enables spread to bit lanes
  function automatic sdram_wb_pkg::line_data_t byte_mask(input sdram_wb_pkg::line_be_t be);
    sdram_wb_pkg::line_data_t m;
    for (int i = 0; i < sdram_wb_pkg::LINE_BYTES; i++)
      m[i*8 +: 8] = {8{be[i]}};
    return m;
  endfunction

  // Each accepted line against the oldest expected one
  always @(negedge HCLK)
  begin
    if (HRESETn)
    begin
      check_value("wr_req_o held stable", hold_err, 0);
      if (!hreadyout_o)
        stall_count++;
      if (rec_valid)
      begin
        if (exp_q.size() == 0)
          fail_run("Write request arrived with no line expected");
        else
        begin
          exp_req = exp_q.pop_front();
          mask    = byte_mask(exp_req.be);
          check_value("wr_req_o.tag", rec_req.tag, exp_req.tag);
          check_value("wr_req_o.be", rec_req.be, exp_req.be);
          check_value("wr_req_o.data", rec_req.data & mask, exp_req.data & mask);
          got_count++;
        end
      end
    end
  end

  ////////////////////
  // Reference model

  task automatic push_line();
    exp_q.push_back('{act_tag, act_be, act_data});
    push_count++;
    act_be    = '0;
    act_dirty = 1'b0;
  endtask

  task automatic model_write(input stim_t s);
    sdram_wb_pkg::tag_t     tag;
    int                     idx;
    sdram_wb_pkg::word_be_t be;
    tag = s.addr[31:4];
    idx = int'(s.addr[3:2]);
    // Lane by lane, byte matches both low bits, halfword only bit 1
    for (int b = 0; b < 4; b++)
    begin
      case (s.size)
        sdram_wb_pkg::HSIZE_BYTE:  be[b] = (b == int'(s.addr[1:0]));
        sdram_wb_pkg::HSIZE_HWORD: be[b] = ((b / 2) == int'(s.addr[1]));
        default:                   be[b] = 1'b1;
      endcase
    end
    // Different line while dirty flushes the old one
    if (act_dirty && tag != act_tag)
      push_line();
    act_tag   = tag;
    act_dirty = 1'b1;
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
      begin
        act_be[idx*4 + b]            = 1'b1;
        act_data[(idx*4 + b)*8 +: 8] = s.data[b*8 +: 8];
      end
    end
    // Idle gap longer than the timer
    if (s.tmo != 0 && int'(s.idle) > (1 << s.tmo))
      push_line();
  endtask

  ////////////////////
  // Bus driving

  // Loops until an edge with hreadyout_o high
  task automatic wait_accept(input string what);
    int   n;
    logic rdy;
    n   = 0;
    rdy = 1'b0;
    while (!rdy)
    begin
      @(negedge HCLK);
      rdy = hreadyout_o;
      @(posedge HCLK);
      n++;
      if (!rdy && n > 400)
        fail_run({"Timeout waiting for hreadyout_o in ", what});
    end
  endtask

  task automatic ahb_write(input stim_t s);
    hsel_i    <= 1'b1;
    htrans_i  <= sdram_wb_pkg::HTRANS_NONSEQ;
    hwrite_i  <= 1'b1;
    hsize_i   <= s.size;
    haddr_i   <= s.addr;
    timeout_i <= s.tmo;
    slow_mode <= s.slow;
    wait_accept("address phase");
    hsel_i    <= 1'b0;
    htrans_i  <= sdram_wb_pkg::HTRANS_IDLE;
    hwrite_i  <= 1'b0;
    hwdata_i  <= s.data;
    wait_accept("data phase");
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0)
    begin
      @(negedge HCLK);
      n++;
      if (n > 1000)
        fail_run("Timeout waiting for the last write requests");
    end
  endtask

  initial
  begin
    HRESETn     = 1'b0;
    hsel_i      = 1'b0;
    htrans_i    = sdram_wb_pkg::HTRANS_IDLE;
    hwrite_i    = 1'b0;
    hsize_i     = sdram_wb_pkg::HSIZE_WORD;
    haddr_i     = '0;
    hwdata_i    = '0;
    timeout_i   = '0;
    slow_mode   = 1'b0;
    act_tag     = '0;
    act_be      = '0;
    act_data    = '0;
    act_dirty   = 1'b0;
    push_count  = 0;
    got_count   = 0;
    stall_count = 0;
    repeat (5) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check_value("wrreq_o after reset", wrreq_o, 0);
    check_value("hreadyout_o after reset", hreadyout_o, 1);
    @(posedge HCLK);

    for (int r = 0; r < NROWS; r++)
    begin
      model_write(stim[r]);
      ahb_write(stim[r]);
      repeat (stim[r].idle) @(posedge HCLK);
    end

    // Dirty line with timer off gave nothing
    check_value("requests before final flush", got_count, push_count);
    check_value("back-pressure stall cycles seen", stall_count != 0, 1);

    // Timer back on to empty the last line
    push_line();
    timeout_i <= 4'd1;
    wait_drain();
    @(negedge HCLK);
    check_value("wrreq_o at end", wrreq_o, 0);
    check_value("hreadyout_o at end", hreadyout_o, 1);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: tb_sdram_model.sv
/* Scheduler model for the testbench: accepts write requests
   after a fixed or random delay and records each accepted line */

`timescale 1ns/1ps

module tb_sdram_model (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  wrreq_i,
  input  sdram_wb_pkg::wb_req_t wr_req_i,
  input  logic                  slow_i,
  output logic                  wrrdy_o,
  output logic                  rec_valid_o,
  output sdram_wb_pkg::wb_req_t rec_req_o,
  output logic                  hold_err_o
);

  integer                seed = 57;
  logic                  busy_q;
  logic [3:0]            delay_q;
  logic                  pend_q;
  sdram_wb_pkg::wb_req_t held_q;

  ////////////////////
  // Accept side

  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      wrrdy_o     <= 1'b0;
      busy_q      <= 1'b0;
      delay_q     <= '0;
      rec_valid_o <= 1'b0;
    end
    else
    begin
      rec_valid_o <= 1'b0;
      if (wrreq_i && wrrdy_o)
      begin
        // Line taken at this edge
        rec_valid_o <= 1'b1;
        rec_req_o   <= wr_req_i;
        busy_q      <= 1'b0;
        wrrdy_o     <= !slow_i;
      end
      else if (slow_i)
      begin
        if (!busy_q)
        begin
          wrrdy_o <= 1'b0;
          if (wrreq_i)
          begin
            busy_q  <= 1'b1;
            delay_q <= 4'd2 + 4'($unsigned($random(seed)) % 10);
          end
        end
        else if (delay_q != '0)
          delay_q <= delay_q - 4'd1;
        else
          wrrdy_o <= 1'b1;
      end
      else
        wrrdy_o <= 1'b1;  // fast mode, always ready
    end
  end

  ////////////////////
  // Stability watch

  // Pending request must keep its strobe and contents
  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      pend_q     <= 1'b0;
      hold_err_o <= 1'b0;
    end
    else
    begin
      pend_q <= wrreq_i && !wrrdy_o;
      held_q <= wr_req_i;
      if (pend_q && (!wrreq_i || wr_req_i != held_q))
        hold_err_o <= 1'b1;
    end
  end

endmodule

// File: sdram_wb_top.sv
/* AHB write-buffer slave top: decode, ping-pong storage
   and flush control */

`timescale 1ns/1ps

module sdram_wb_top (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  // AHB
  input  logic                    hsel_i,
  input  logic [1:0]              htrans_i,
  input  logic                    hwrite_i,
  input  logic [2:0]              hsize_i,
  input  sdram_wb_pkg::haddr_t    haddr_i,
  input  sdram_wb_pkg::hdata_t    hwdata_i,
  input  logic                    hready_i,
  output logic                    hreadyout_o,
  // Scheduler
  output logic                    wrreq_o,
  output sdram_wb_pkg::wb_req_t   wr_req_o,
  input  logic                    wrrdy_i,
  // Configuration
  input  sdram_wb_pkg::timeout_t  timeout_i
);

  // Decode to storage and flush control
  logic                   addr_wr;
  sdram_wb_pkg::tag_t     addr_tag;
  logic                   data_wr;
  sdram_wb_pkg::tag_t     data_tag;
  sdram_wb_pkg::idx_t     data_idx;
  sdram_wb_pkg::word_be_t data_be;

  // Flush control to storage
  logic                   bank;
  logic                   toggle;
  logic                   we;
  logic                   req_done;

  // Storage status back
  sdram_wb_pkg::tag_t     active_tag;
  logic                   active_dirty;
  logic                   other_dirty;

  ahb_write_decode u_decode (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hsel_i     (hsel_i),
    .htrans_i   (htrans_i),
    .hwrite_i   (hwrite_i),
    .hsize_i    (hsize_i),
    .haddr_i    (haddr_i),
    .hready_i   (hready_i),
    .addr_wr_o  (addr_wr),
    .addr_tag_o (addr_tag),
    .data_wr_o  (data_wr),
    .data_tag_o (data_tag),
    .data_idx_o (data_idx),
    .data_be_o  (data_be)
  );

  wb_storage u_storage (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .bank_i         (bank),
    .toggle_i       (toggle),
    .we_i           (we),
    .req_done_i     (req_done),
    .wr_tag_i       (data_tag),
    .wr_idx_i       (data_idx),
    .wr_be_i        (data_be),
    .hwdata_i       (hwdata_i),
    .active_tag_o   (active_tag),
    .active_dirty_o (active_dirty),
    .other_dirty_o  (other_dirty),
    .req_o          (wr_req_o)
  );

  wb_flush_ctrl u_flush (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .hready_i       (hready_i),
    .addr_wr_i      (addr_wr),
    .addr_tag_i     (addr_tag),
    .data_wr_i      (data_wr),
    .active_tag_i   (active_tag),
    .active_dirty_i (active_dirty),
    .other_dirty_i  (other_dirty),
    .wrrdy_i        (wrrdy_i),
    .timeout_i      (timeout_i),
    .bank_o         (bank),
    .toggle_o       (toggle),
    .we_o           (we),
    .req_done_o     (req_done),
    .wrreq_o        (wrreq_o),
    .hreadyout_o    (hreadyout_o)
  );

endmodule

// File: wb_flush_ctrl.sv
/* Flush control: miss and idle-timer detection, bank select,
   request strobe towards the scheduler and AHB wait states */

`timescale 1ns/1ps

module wb_flush_ctrl (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    hready_i,
  input  logic                    addr_wr_i,
  input  sdram_wb_pkg::tag_t      addr_tag_i,
  input  logic                    data_wr_i,
  input  sdram_wb_pkg::tag_t      active_tag_i,
  input  logic                    active_dirty_i,
  input  logic                    other_dirty_i,
  input  logic                    wrrdy_i,
  input  sdram_wb_pkg::timeout_t  timeout_i,
  output logic                    bank_o,
  output logic                    toggle_o,
  output logic                    we_o,
  output logic                    req_done_o,
  output logic                    wrreq_o,
  output logic                    hreadyout_o
);

  typedef enum logic {
    st_idle,
    st_wait_other
  } flush_state_t;

  flush_state_t         state_q;
  flush_state_t         state_d;
  logic                 bank_q;
  logic                 toggle_dly_q;
  sdram_wb_pkg::timer_t timer_q;

  logic                 miss;
  logic                 timer_expired;
  logic                 other_free;

  ////////////////////
  // Flush triggers

  // Data beat lands when the bus is ready
  assign we_o       = data_wr_i & hready_i;
  assign req_done_o = wrreq_o & wrrdy_i;

  // Waiting bank empty, or emptied at this edge
  assign other_free = ~other_dirty_i | req_done_o;

  // Write to a line other than the one being merged
  assign miss = hready_i & addr_wr_i & active_dirty_i
                & (addr_tag_i != active_tag_i);

  // Idle expiry, only with nothing in flight on the bus
  assign timer_expired = (timeout_i != '0) & (timer_q == '0) & active_dirty_i
                         & ~we_o & ~addr_wr_i;

  // Idle countdown, restarted by each write beat
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      timer_q <= '0;
    else if (we_o)
      timer_q <= sdram_wb_pkg::timer_t'(1) << timeout_i;
    else if (active_dirty_i && timer_q != '0)
      timer_q <= timer_q - 1'b1;
  end

  ////////////////////
  // FSM

  always_comb
  begin
    state_d  = state_q;
    toggle_o = 1'b0;
    case (state_q)
      st_idle:
        if (miss || timer_expired)
        begin
          // Swap now or hold the bus until the old line is taken
          if (other_free)
            toggle_o = 1'b1;
          else
            state_d = st_wait_other;
        end
      st_wait_other:
        if (other_free)
        begin
          toggle_o = 1'b1;
          state_d  = st_idle;
        end
      default:
        state_d = st_idle;
    endcase
  end

  // Wait states only while a flush is blocked
  assign hreadyout_o = (state_q == st_idle);
  assign bank_o      = bank_q;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q      <= st_idle;
      bank_q       <= 1'b0;
      toggle_dly_q <= 1'b0;
      wrreq_o      <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      bank_q       <= bank_q ^ toggle_o;
      // Extra cycle for the registered storage read
      toggle_dly_q <= toggle_o;
      // Raised after a swap, held until taken
      wrreq_o      <= toggle_dly_q | (wrreq_o & ~wrrdy_i);
    end
  end

  ////////////////////
  // Checks

  // Pending line keeps its strobe and stays dirty until the scheduler takes it
  a_wrreq_held: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    wrreq_o && !wrrdy_i |=> wrreq_o && other_dirty_i
  );

  // No swap while the waiting bank is still on its way out
  a_toggle_free: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    toggle_o |-> !toggle_dly_q && (!wrreq_o || wrrdy_i)
  );

endmodule

// File: wb_storage.sv
/* Ping-pong line storage with byte-enable merging, tags and
   dirty flags, and the registered request view of the waiting bank */

`timescale 1ns/1ps

module wb_storage (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    bank_i,
  input  logic                    toggle_i,
  input  logic                    we_i,
  input  logic                    req_done_i,
  input  sdram_wb_pkg::tag_t      wr_tag_i,
  input  sdram_wb_pkg::idx_t      wr_idx_i,
  input  sdram_wb_pkg::word_be_t  wr_be_i,
  input  sdram_wb_pkg::hdata_t    hwdata_i,
  output sdram_wb_pkg::tag_t      active_tag_o,
  output logic                    active_dirty_o,
  output logic                    other_dirty_o,
  output sdram_wb_pkg::wb_req_t   req_o
);

  // Two banks, index is the bank number
  sdram_wb_pkg::line_data_t data_q  [2];
  sdram_wb_pkg::line_be_t   be_q    [2];
  sdram_wb_pkg::tag_t       tag_q   [2];
  logic                     dirty_q [2];

  logic                     other;
  sdram_wb_pkg::line_be_t   wr_line_be;
  sdram_wb_pkg::line_data_t wr_line_data;

  assign other = ~bank_i;

  ////////////////////
  // Write path

  // Word lanes moved to their place in the line
  assign wr_line_be   = sdram_wb_pkg::line_be_t'(wr_be_i)
                        << (int'(wr_idx_i) * $bits(sdram_wb_pkg::word_be_t));
  // Same word on every line slot, the enables pick one
  assign wr_line_data = {sdram_wb_pkg::LINE_WORDS{hwdata_i}};

  // Byte-wise merge into the active bank
  always_ff @(posedge HCLK)
  begin
    if (we_i)
    begin
      for (int i = 0; i < sdram_wb_pkg::LINE_BYTES; i++)
      begin
        if (wr_line_be[i])
          data_q[bank_i][i*8 +: 8] <= wr_line_data[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (we_i)
      tag_q[bank_i] <= wr_tag_i;
  end

  // Enables accumulate, fresh bank starts empty
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      be_q[0] <= '0;
      be_q[1] <= '0;
    end
    else
    begin
      if (toggle_i)
        be_q[other] <= '0;
      if (we_i)
        be_q[bank_i] <= be_q[bank_i] | wr_line_be;
    end
  end

  // Set by a write, cleared once the scheduler takes the line
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dirty_q[0] <= 1'b0;
      dirty_q[1] <= 1'b0;
    end
    else
    begin
      if (we_i)
        dirty_q[bank_i] <= 1'b1;
      if (req_done_i)
        dirty_q[other] <= 1'b0;
    end
  end

  ////////////////////
  // Status and request

  // Includes the beat being written this cycle
  assign active_dirty_o = dirty_q[bank_i] | we_i;
  assign active_tag_o   = we_i ? wr_tag_i : tag_q[bank_i];
  assign other_dirty_o  = dirty_q[other];

  // Registered read of the waiting bank
  always_ff @(posedge HCLK)
  begin
    req_o.tag  <= tag_q[other];
    req_o.be   <= be_q[other];
    req_o.data <= data_q[other];
  end

endmodule

// File: ahb_write_decode.sv
/* AHB write qualification, byte-enable generation
   and the address-to-data phase pipeline registers */

`timescale 1ns/1ps

module ahb_write_decode (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   hsel_i,
  input  logic [1:0]             htrans_i,
  input  logic                   hwrite_i,
  input  logic [2:0]             hsize_i,
  input  sdram_wb_pkg::haddr_t   haddr_i,
  input  logic                   hready_i,
  output logic                   addr_wr_o,
  output sdram_wb_pkg::tag_t     addr_tag_o,
  output logic                   data_wr_o,
  output sdram_wb_pkg::tag_t     data_tag_o,
  output sdram_wb_pkg::idx_t     data_idx_o,
  output sdram_wb_pkg::word_be_t data_be_o
);

  logic                   trans_valid;
  sdram_wb_pkg::word_be_t addr_be;

  ////////////////////
  // Address phase

  // Only NONSEQ and SEQ carry a transfer
  always_comb
  begin
    case (htrans_i)
      sdram_wb_pkg::HTRANS_IDLE,
      sdram_wb_pkg::HTRANS_BUSY:   trans_valid = 1'b0;
      sdram_wb_pkg::HTRANS_NONSEQ,
      sdram_wb_pkg::HTRANS_SEQ:    trans_valid = 1'b1;
      default:                     trans_valid = 1'b0;
    endcase
  end

  assign addr_wr_o  = hsel_i & hwrite_i & trans_valid;
  assign addr_tag_o = haddr_i[sdram_wb_pkg::HADDR_W-1 -: $bits(sdram_wb_pkg::tag_t)];

  // Lanes selected by size and low address bits
  always_comb
  begin
    case (hsize_i)
      sdram_wb_pkg::HSIZE_BYTE:
        addr_be = sdram_wb_pkg::word_be_t'(1) << haddr_i[1:0];
      sdram_wb_pkg::HSIZE_HWORD:
        addr_be = sdram_wb_pkg::word_be_t'(3) << {haddr_i[1], 1'b0};
      sdram_wb_pkg::HSIZE_WORD:
        addr_be = '1;
      // Wider than the bus is illegal, no lanes
      default:
        addr_be = '0;
    endcase
  end

  ////////////////////
  // Data phase

  // Strobe follows every sampled transfer
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      data_wr_o <= 1'b0;
    else if (hready_i)
      data_wr_o <= addr_wr_o;
  end

  // Location and lanes for the data beat
  always_ff @(posedge HCLK)
  begin
    if (hready_i)
    begin
      data_tag_o <= addr_tag_o;
      data_idx_o <= haddr_i[$clog2(sdram_wb_pkg::LINE_BYTES)-1 -: $bits(sdram_wb_pkg::idx_t)];
      data_be_o  <= addr_be;
    end
  end

endmodule

// File: sdram_wb_pkg.sv
/* Shared widths, vector types and AHB encodings
   plus the write request record for the write buffer */

package sdram_wb_pkg;

  ////////////////////
  // Widths

  // AHB bus
  localparam int HADDR_W    = 32;
  localparam int HDATA_W    = 32;

  // One buffer line
  localparam int LINE_BYTES = 16;
  localparam int LINE_WORDS = 4;

  ////////////////////
  // Vector types

  typedef logic [HADDR_W-1:0]                     haddr_t;
  typedef logic [HDATA_W-1:0]                     hdata_t;
  typedef logic [HDATA_W/8-1:0]                   word_be_t;

  // Line address, everything above the line offset
  typedef logic [HADDR_W-$clog2(LINE_BYTES)-1:0]  tag_t;
  // Word within a line
  typedef logic [$clog2(LINE_WORDS)-1:0]          idx_t;

  typedef logic [LINE_BYTES*8-1:0]                line_data_t;
  typedef logic [LINE_BYTES-1:0]                  line_be_t;

  // Timer exponent, zero turns the timer off
  typedef logic [3:0]                             timeout_t;
  typedef logic [15:0]                            timer_t;

  ////////////////////
  // AHB encodings

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE    = 3'b000;
  localparam logic [2:0] HSIZE_HWORD   = 3'b001;
  localparam logic [2:0] HSIZE_WORD    = 3'b010;

  // Request towards the scheduler
  typedef struct packed {
    tag_t       tag;
    line_be_t   be;
    line_data_t data;
  } wb_req_t;

endpackage
